//--- verilog/z80_bus_macros.svh
// --------------------------------------------------------------------
// Bus map and serial timing constants. BANK_COUNT << BANK_ADDR_W
// must equal the 64 KiB Z80 space. BAUD_DIV is truncated to whole clocks
// --------------------------------------------------------------------
`ifndef Z80_BUS_MACROS_SVH
`define Z80_BUS_MACROS_SVH

// Memory map
`define BANK_COUNT		4			// Banks over the 64 KiB space
`define BANK_ADDR_W		14			// 16 KiB per bank

// I/O map
`define SERIAL_PORT		8'h10		// Transmit data and status port

// Serial timing
`define CLK_FREQ		43200000	// System clock in Hz
`define BAUD_RATE		115200		// 8N1 line rate
`define BAUD_DIV		(`CLK_FREQ / `BAUD_RATE)	// 375 clocks per bit

`endif

//--- verilog/bus_types_pkg.sv
// --------------------------------------------------------------------
// Z80 bus widths. Bank index width follows BANK_COUNT
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

package bus_types_pkg;

	// CPU side
	typedef logic [15:0]	bus_addr_t;		// Full 16-bit address
	typedef logic [7:0]		bus_data_t;		// One data byte

	// ----------------------------------------------------------------
	// Bank split of the address
	// ----------------------------------------------------------------
	// Low part, location inside one bank
	typedef logic [`BANK_ADDR_W-1:0]			bank_offset_t;

	// High part, which bank answers
	typedef logic [$clog2(`BANK_COUNT)-1:0]		bank_index_t;

endpackage

//--- verilog/serial_types_pkg.sv
// --------------------------------------------------------------------
// Serial transmitter types. Baud counter sized from BAUD_DIV
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

package serial_types_pkg;

	// Frame phases of one 8N1 character
	typedef enum logic [1:0] {
		tx_idle,		// Line high, ready for a byte
		tx_start,		// Start bit, line low
		tx_data,		// Eight data bits, LSB first
		tx_stop			// Stop bit, line high
	} tx_state_t;

	typedef logic [2:0]						bit_count_t;	// Data bit index 0..7
	typedef logic [$clog2(`BAUD_DIV)-1:0]	baud_count_t;	// Clocks within one bit

endpackage

//--- verilog/bus_decoder.sv
// --------------------------------------------------------------------
// Combinational chip selects. No wait states, no refresh decode
// Interrupt acknowledge (iorq_n and m1_n low) selects nothing
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

module bus_decoder (
	input								mreq_n,
	input								iorq_n,
	input								m1_n,
	input	bus_types_pkg::bus_addr_t	a,
	output	logic [`BANK_COUNT-1:0]		bank_cs_n,		// One per bank, active low
	output	logic						port_cs_n		// Serial port, active low
);
	import bus_types_pkg::*;

	bank_index_t	w_bank;			// Top address bits
	logic			w_io_cycle;		// Real I/O, not an INTA

	// ----------------------------------------------------------------
	// Memory
	// ----------------------------------------------------------------
	assign w_bank = a[$bits(bus_addr_t)-1 -: $bits(bank_index_t)];

	always_comb begin
		for (int i = 0; i < `BANK_COUNT; i++) begin
			// Follow mreq_n only for the addressed bank
			bank_cs_n[i] = (w_bank == bank_index_t'(i)) ? mreq_n : 1'b1;
		end
	end

	// ----------------------------------------------------------------
	// I/O
	// ----------------------------------------------------------------
	// M1 with IORQ is the acknowledge cycle
	assign w_io_cycle	= !iorq_n && m1_n;
	assign port_cs_n	= !(w_io_cycle && (a[7:0] == `SERIAL_PORT));	// Low byte only

	// Only one bank may drive its return at a time
	always_comb begin
		a_one_bank: assert ($countones(~bank_cs_n) <= 1)
			else $error("bus_decoder: more than one bank selected, %h", bank_cs_n);
	end

endmodule

//--- verilog/sram_bank.sv
// --------------------------------------------------------------------
// 16 KiB single port RAM bank. Read data valid the cycle after rd_n
// is sampled low. Simultaneous rd_n and wr_n is not a legal Z80 cycle
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

module sram_bank (
	input								clk,
	input								ff_reset_n,
	input								cs_n,
	input								rd_n,
	input								wr_n,
	input	bus_types_pkg::bank_offset_t	offset,
	input	bus_types_pkg::bus_data_t	wdata,
	output	bus_types_pkg::bus_data_t	rdata,
	output	logic						rdata_en
);
	import bus_types_pkg::*;

	localparam int DEPTH = 1 << `BANK_ADDR_W;

	bus_data_t	ff_mem [0:DEPTH-1];		// Block RAM
	bus_data_t	ff_rdata;
	logic		ff_rdata_en;
	logic		w_read;
	logic		w_write;

	assign w_read	= !cs_n && !rd_n;
	assign w_write	= !cs_n && !wr_n;

	// ----------------------------------------------------------------
	// Array access
	// ----------------------------------------------------------------
	// Written on every edge the strobe is held
	always_ff @(posedge clk) begin
		if (w_write) begin
			ff_mem[offset] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (w_read) begin
			ff_rdata <= ff_mem[offset];		// Old data on same-edge write
		end
	end

	// One pulse per sampled read edge
	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_rdata_en <= 1'b0;
		end
		else begin
			ff_rdata_en <= w_read;
		end
	end

	assign rdata	= ff_rdata;
	assign rdata_en	= ff_rdata_en;

	// CPU never reads and writes in one cycle
	a_no_rd_wr: assert property (@(posedge clk) disable iff (!ff_reset_n)
		!cs_n |-> (rd_n || wr_n))
		else $error("sram_bank: rd_n and wr_n both low while selected");

endmodule

//--- verilog/read_data_mux.sv
// --------------------------------------------------------------------
// Read return merge. Purely combinational, adds no latency
// Returns are expected one-hot; others must be gated off
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

module read_data_mux (
	input	bus_types_pkg::bus_data_t	bank_rdata [`BANK_COUNT],
	input	logic [`BANK_COUNT-1:0]		bank_rdata_en,
	input	bus_types_pkg::bus_data_t	port_rdata,
	input								port_rdata_en,
	output	bus_types_pkg::bus_data_t	rdata,
	output	logic						rdata_en
);
	import bus_types_pkg::*;

	bus_data_t	w_merge;		// OR of all enabled returns

	// ----------------------------------------------------------------
	// Merge
	// ----------------------------------------------------------------
	always_comb begin
		w_merge = port_rdata_en ? port_rdata : '0;
		for (int i = 0; i < `BANK_COUNT; i++) begin
			if (bank_rdata_en[i]) begin
				w_merge = w_merge | bank_rdata[i];
			end
		end
	end

	assign rdata	= w_merge;
	assign rdata_en	= port_rdata_en || (|bank_rdata_en);	// Any target answered

	// Decoder and targets keep returns exclusive
	always_comb begin
		a_one_return: assert ($countones({bank_rdata_en, port_rdata_en}) <= 1)
			else $error("read_data_mux: overlapping returns %h %b",
				bank_rdata_en, port_rdata_en);
	end

endmodule

//--- verilog/serial_tx_port.sv
// --------------------------------------------------------------------
// Transmit-only 8N1 port. Writes while busy are dropped, no FIFO
// Status read gives busy in bit 0. One write per falling of wr_n
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

module serial_tx_port (
	input								clk,
	input								ff_reset_n,
	input								cs_n,
	input								rd_n,
	input								wr_n,
	input	bus_types_pkg::bus_data_t	wdata,
	output	bus_types_pkg::bus_data_t	rdata,
	output	logic						rdata_en,
	output	logic						serial_tx
);
	import bus_types_pkg::*;
	import serial_types_pkg::*;

	tx_state_t		ff_state;
	bit_count_t		ff_bit_cnt;
	baud_count_t	ff_baud_cnt;
	bus_data_t		ff_shift;			// Remaining data bits
	logic			ff_tx;
	logic			ff_wr_prev;			// Write strobe last edge
	bus_data_t		ff_rdata;
	logic			ff_rdata_en;
	logic			w_wr_req;
	logic			w_wr_start;
	logic			w_baud_end;
	logic			w_busy;

	assign w_wr_req		= !cs_n && !wr_n;
	assign w_busy		= (ff_state != tx_idle);
	assign w_wr_start	= w_wr_req && !ff_wr_prev && !w_busy;	// First edge only
	assign w_baud_end	= (ff_baud_cnt == baud_count_t'(`BAUD_DIV - 1));

	// ----------------------------------------------------------------
	// Write edge detect
	// ----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_wr_prev <= 1'b0;
		end
		else begin
			ff_wr_prev <= w_wr_req;
		end
	end

	// Bit period, held at zero when idle
	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_baud_cnt <= '0;
		end
		else if (!w_busy || w_baud_end) begin
			ff_baud_cnt <= '0;
		end
		else begin
			ff_baud_cnt <= ff_baud_cnt + 1'b1;
		end
	end

	// Loaded on accept, shifted as each bit goes out
	always_ff @(posedge clk) begin
		if (w_wr_start) begin
			ff_shift <= wdata;
		end
		else if (w_baud_end && (ff_state == tx_start || ff_state == tx_data)) begin
			ff_shift <= ff_shift >> 1;
		end
	end

	// ----------------------------------------------------------------
	// Frame FSM
	// ----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_state	<= tx_idle;
			ff_bit_cnt	<= '0;
			ff_tx		<= 1'b1;		// Line idles high
		end
		else begin
			case (ff_state)
			tx_idle: begin
				if (w_wr_start) begin
					ff_state	<= tx_start;
					ff_tx		<= 1'b0;	// Start bit next cycle
				end
			end
			tx_start: begin
				if (w_baud_end) begin
					ff_state	<= tx_data;
					ff_bit_cnt	<= '0;
					ff_tx		<= ff_shift[0];		// LSB first
				end
			end
			tx_data: begin
				if (w_baud_end) begin
					if (ff_bit_cnt == 3'd7) begin
						ff_state	<= tx_stop;
						ff_tx		<= 1'b1;
					end
					else begin
						ff_bit_cnt	<= ff_bit_cnt + 1'b1;
						ff_tx		<= ff_shift[0];
					end
				end
			end
			tx_stop: begin
				if (w_baud_end) begin
					ff_state <= tx_idle;		// Busy drops here
				end
			end
			default: begin
				ff_state <= tx_idle;
			end
			endcase
		end
	end

	// ----------------------------------------------------------------
	// Status read, same timing as a bank
	// ----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!cs_n && !rd_n) begin
			ff_rdata <= {7'd0, w_busy};
		end
	end

	always_ff @(posedge clk) begin
		if (!ff_reset_n) begin
			ff_rdata_en <= 1'b0;
		end
		else begin
			ff_rdata_en <= !cs_n && !rd_n;
		end
	end

	assign rdata		= ff_rdata;
	assign rdata_en		= ff_rdata_en;
	assign serial_tx	= ff_tx;

	// Line must rest high between frames
	a_idle_high: assert property (@(posedge clk) disable iff (!ff_reset_n)
		(ff_state == tx_idle) |-> serial_tx)
		else $error("serial_tx_port: line low while idle");

endmodule

//--- verilog/z80_bus_system.sv
// --------------------------------------------------------------------
// Z80 memory and I/O subsystem without the CPU. Write data is a
// separate input, no tri-state bus. No interrupts or wait states
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

module z80_bus_system (
	input								clk,
	input								ff_reset_n,
	input								mreq_n,
	input								iorq_n,
	input								m1_n,
	input								rd_n,
	input								wr_n,
	input	bus_types_pkg::bus_addr_t	a,
	input	bus_types_pkg::bus_data_t	wdata,
	output	bus_types_pkg::bus_data_t	rdata,
	output	logic						rdata_en,
	output	logic						serial_tx
);
	import bus_types_pkg::*;

	logic [`BANK_COUNT-1:0]		w_bank_cs_n;
	logic						w_port_cs_n;
	bus_data_t					w_bank_rdata [`BANK_COUNT];
	logic [`BANK_COUNT-1:0]		w_bank_rdata_en;
	bus_data_t					w_port_rdata;
	logic						w_port_rdata_en;

	// ----------------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------------
	bus_decoder u_decoder (
		.mreq_n			( mreq_n			),
		.iorq_n			( iorq_n			),
		.m1_n			( m1_n				),
		.a				( a					),
		.bank_cs_n		( w_bank_cs_n		),
		.port_cs_n		( w_port_cs_n		)
	);

	// ----------------------------------------------------------------
	// RAM banks, 0000h upward
	// ----------------------------------------------------------------
	for (genvar i = 0; i < `BANK_COUNT; i++) begin : bank_gen
		sram_bank u_bank (
			.clk			( clk						),
			.ff_reset_n		( ff_reset_n				),
			.cs_n			( w_bank_cs_n[i]			),
			.rd_n			( rd_n						),
			.wr_n			( wr_n						),
			.offset			( a[`BANK_ADDR_W-1:0]		),	// Low bits only
			.wdata			( wdata						),
			.rdata			( w_bank_rdata[i]			),
			.rdata_en		( w_bank_rdata_en[i]		)
		);
	end

	// Serial transmitter at SERIAL_PORT
	serial_tx_port u_serial (
		.clk			( clk				),
		.ff_reset_n		( ff_reset_n		),
		.cs_n			( w_port_cs_n		),
		.rd_n			( rd_n				),
		.wr_n			( wr_n				),
		.wdata			( wdata				),
		.rdata			( w_port_rdata		),
		.rdata_en		( w_port_rdata_en	),
		.serial_tx		( serial_tx			)
	);

	// Read return to the CPU
	read_data_mux u_mux (
		.bank_rdata		( w_bank_rdata		),
		.bank_rdata_en	( w_bank_rdata_en	),
		.port_rdata		( w_port_rdata		),
		.port_rdata_en	( w_port_rdata_en	),
		.rdata			( rdata				),
		.rdata_en		( rdata_en			)
	);

endmodule

//--- tests/tb_z80_bus_system.sv
// --------------------------------------------------------------------
// Testbench acting as the Z80 bus master. Needs the 43.2 MHz BAUD_DIV
// of the macros header. Memory model only holds bytes written here
// --------------------------------------------------------------------
`include "z80_bus_macros.svh"

module tb_z80_bus_system;
	timeunit 1ns;
	timeprecision 100ps;
	import bus_types_pkg::*;

	localparam int BAUD_DIV = `BAUD_DIV;
	localparam int MEM_OPS = 64;						// Random writes in the memory test
	localparam int CYCLE_LIMIT = 3 * 10 * BAUD_DIV + 8 * MEM_OPS + 2000;
	localparam bus_addr_t PORT_ADDR = {8'h00, `SERIAL_PORT};

	logic		clk;
	logic		ff_reset_n;
	logic		mreq_n;
	logic		iorq_n;
	logic		m1_n;
	logic		rd_n;
	logic		wr_n;
	bus_addr_t	a;
	bus_data_t	wdata;
	bus_data_t	rdata;
	logic		rdata_en;
	logic		serial_tx;

	bus_data_t	ref_mem [0:65535];		// Expected memory contents
	bus_data_t	port_exp;				// Expected status byte
	logic		mem_rd;
	logic		io_rd;
	logic		exp_en;					// Read return due this cycle
	bus_data_t	exp_data;
	logic [9:0]	frame_bits;				// Start in bit 0, stop in bit 9
	bus_data_t	frame_exp;
	logic		frame_done;
	logic		frame_check;
	int			frame_count = 0;
	int			exp_frames = 0;
	int			data_errors = 0;
	int			serial_errors = 0;
	int			state_errors = 0;
	int			cycles = 0;

	z80_bus_system dut_i (
		.clk		( clk		),
		.ff_reset_n	( ff_reset_n	),
		.mreq_n		( mreq_n	),
		.iorq_n		( iorq_n	),
		.m1_n		( m1_n		),
		.rd_n		( rd_n		),
		.wr_n		( wr_n		),
		.a			( a			),
		.wdata		( wdata		),
		.rdata		( rdata		),
		.rdata_en	( rdata_en	),
		.serial_tx	( serial_tx	)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;		// 4 ns period
	end

	// --------------------------------------------------------------------
	// Reference model of the read returns
	// --------------------------------------------------------------------
	assign mem_rd	= !mreq_n && !rd_n;
	assign io_rd	= !iorq_n && m1_n && !rd_n && (a[7:0] == `SERIAL_PORT);	// No INTA

	always @(posedge clk) begin
		if (!ff_reset_n) begin
			exp_en <= 1'b0;
		end
		else begin
			exp_en		<= mem_rd || io_rd;		// One pulse per sampled edge
			exp_data	<= io_rd ? port_exp : ref_mem[a];
		end
		if (!mreq_n && !wr_n) begin
			ref_mem[a] <= wdata;
		end
	end

	// Frame sampler, mid-bit on the falling edge
	initial begin
		frame_done = 1'b0;
		frame_bits = '0;
		wait (ff_reset_n);
		forever begin
			@(negedge clk);
			if (!serial_tx) begin
				repeat (BAUD_DIV / 2) @(negedge clk);	// Middle of start bit
				for (int k = 0; k < 10; k++) begin
					frame_bits = {serial_tx, frame_bits[9:1]};
					if (k < 9) begin
						repeat (BAUD_DIV) @(negedge clk);
					end
				end
				frame_count++;
				frame_done = 1'b1;
				@(negedge clk);
				frame_done = 1'b0;
			end
		end
	end

	// --------------------------------------------------------------------
	// Checks
	// --------------------------------------------------------------------
	a_reset_state: assert property (@(posedge clk) $rose(ff_reset_n) |-> (!rdata_en && serial_tx))
		else begin
			state_errors++;
			$display("FAIL rdata_en %h serial_tx %h after reset, expected 0 and 1",
				$sampled(rdata_en), $sampled(serial_tx));
		end

	a_rdata_en: assert property (@(posedge clk) disable iff (!ff_reset_n) rdata_en == exp_en)
		else begin
			data_errors++;
			$display("FAIL rdata_en: got %h, expected %h", $sampled(rdata_en), $sampled(exp_en));
		end

	a_rdata: assert property (@(posedge clk) disable iff (!ff_reset_n) exp_en |-> rdata == exp_data)
		else begin
			data_errors++;
			$display("FAIL rdata: got %h, expected %h", $sampled(rdata), $sampled(exp_data));
		end

	a_frame: assert property (@(posedge clk) frame_done |-> frame_bits == {1'b1, frame_exp, 1'b0})
		else begin
			serial_errors++;
			$display("FAIL serial_tx frame: got %h, expected %h",
				$sampled(frame_bits), {1'b1, $sampled(frame_exp), 1'b0});
		end

	a_frame_count: assert property (@(posedge clk) frame_check |-> frame_count == exp_frames)
		else begin
			serial_errors++;
			$display("FAIL frame_count: got %h, expected %h", $sampled(frame_count), exp_frames);
		end

	task automatic print_error_counts();
		$display("Errors: %0d read, %0d serial, %0d reset state", data_errors, serial_errors,
			state_errors);
	endtask

	// Watchdog over the whole run
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			print_error_counts();
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// --------------------------------------------------------------------
	// Bus cycles, driven on the falling edge
	// --------------------------------------------------------------------
	task automatic bus_idle();
		mreq_n	= 1'b1;
		iorq_n	= 1'b1;
		m1_n	= 1'b1;
		rd_n	= 1'b1;
		wr_n	= 1'b1;
	endtask

	task automatic mem_write(input bus_addr_t addr, input bus_data_t data);
		@(negedge clk);
		a		= addr;
		wdata	= data;
		mreq_n	= 1'b0;
		wr_n	= 1'b0;
		@(negedge clk);
		bus_idle();
	endtask

	task automatic mem_read(input bus_addr_t addr, input int edges);
		@(negedge clk);
		a		= addr;
		mreq_n	= 1'b0;
		rd_n	= 1'b0;
		repeat (edges) @(negedge clk);		// One return per edge
		bus_idle();
	endtask

	task automatic io_write(input bus_data_t data);
		@(negedge clk);
		a		= PORT_ADDR;
		wdata	= data;
		iorq_n	= 1'b0;
		wr_n	= 1'b0;
		repeat (2) @(negedge clk);			// Held two edges, still one write
		bus_idle();
	endtask

	task automatic io_read(input bus_data_t expected);
		@(negedge clk);
		a			= PORT_ADDR;
		port_exp	= expected;
		iorq_n		= 1'b0;
		rd_n		= 1'b0;
		@(negedge clk);
		bus_idle();
	endtask

	task automatic int_ack();
		@(negedge clk);
		a		= PORT_ADDR;		// Port address on the bus, still no select
		iorq_n	= 1'b0;
		m1_n	= 1'b0;
		rd_n	= 1'b0;
		@(negedge clk);
		bus_idle();
	endtask

	// --------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------
	initial begin
		bus_addr_t	addr;
		bus_data_t	tx_byte;
		bus_addr_t	addr_list [$];

		void'($urandom(81));
		ff_reset_n	= 1'b0;
		a			= '0;
		wdata		= '0;
		port_exp	= '0;
		frame_exp	= '0;
		frame_check	= 1'b0;
		bus_idle();
		repeat (16) @(posedge clk);
		@(negedge clk);
		ff_reset_n = 1'b1;

		// Random traffic over all four banks
		for (int i = 0; i < MEM_OPS; i++) begin
			addr		= bus_addr_t'($urandom);
			addr[15:14]	= 2'(i);
			mem_write(addr, bus_data_t'($urandom));
			addr_list.push_back(addr);
		end
		foreach (addr_list[i]) begin
			mem_read(addr_list[i], 1 + (i % 2));
		end

		// Same offset in every bank, distinct bytes
		addr	= bus_addr_t'($urandom) & 16'h3FFF;
		tx_byte	= bus_data_t'($urandom);
		for (int i = 0; i < 4; i++) begin
			mem_write({2'(i), addr[13:0]}, tx_byte ^ bus_data_t'(i));
		end
		mem_write(PORT_ADDR, 8'h5A);		// Memory under the port address

		// First frame, status busy, memory untouched by the I/O write
		frame_exp = bus_data_t'($urandom);
		io_write(frame_exp);
		io_read(8'h01);
		for (int i = 0; i < 4; i++) begin
			mem_read({2'(i), addr[13:0]}, 1);
		end
		mem_read(PORT_ADDR, 1);
		wait (frame_count == 1);
		repeat (BAUD_DIV) @(posedge clk);	// Past the end of the stop bit
		io_read(8'h00);

		// Second frame with a dropped write in the middle
		frame_exp = bus_data_t'($urandom);
		io_write(frame_exp);
		repeat (3 * BAUD_DIV) @(negedge clk);
		io_write(~frame_exp);
		io_read(8'h01);
		wait (frame_count == 2);
		repeat (11 * BAUD_DIV) @(posedge clk);	// Room for a stray frame to complete
		io_read(8'h00);
		@(negedge clk);
		exp_frames	= 2;
		frame_check	= 1'b1;
		@(negedge clk);
		frame_check	= 1'b0;

		// INTA with rd_n low, no return expected
		int_ack();
		repeat (4) @(negedge clk);

		print_error_counts();
		if (data_errors + serial_errors + state_errors == 0) begin
			$display("ALL TESTS PASSED");
		end
		else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- z80_bus_system.f
+incdir+verilog
verilog/bus_types_pkg.sv
verilog/serial_types_pkg.sv
verilog/bus_decoder.sv
verilog/sram_bank.sv
verilog/read_data_mux.sv
verilog/serial_tx_port.sv
verilog/z80_bus_system.sv
tests/tb_z80_bus_system.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1

TOP=tb_z80_bus_system
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	-f z80_bus_system.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
	echo "Result: pass"
	exit 0
fi

echo "Result: fail"
exit 1
